// File: sources.f
+incdir+include
source/mem_pkg.sv
source/mem_decode.sv
source/store_align.sv
source/load_extract.sv
source/writeback_select.sv
source/data_ram.sv
source/mem_stage.sv
testbench/tb_clock.sv
testbench/mem_stage_assertions.sv
testbench/tb_mem_stage.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - include
    files:
      - source/mem_pkg.sv
      - source/mem_decode.sv
      - source/store_align.sv
      - source/load_extract.sv
      - source/writeback_select.sv
      - source/data_ram.sv
      - source/mem_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clock.sv
      - testbench/mem_stage_assertions.sv
      - testbench/tb_mem_stage.sv

// File: testbench/tb_mem_stage.sv
`timescale 1ns/1ps
`include "instr_fields.svh"

module tb_mem_stage;

    localparam int N_WORDS = 64; // Address window, in words.
    localparam int N_RAND  = 120;
    localparam int N_JAP   = 30;
    localparam int DRAIN   = 2;
    localparam int N_STEPS = 7 * DRAIN + 3 * N_WORDS + 4 * N_RAND + 2 * N_JAP;
    localparam int TIMEOUT_CYCLES = 2 + 1 + N_STEPS + 20;

    logic              clk, rst_n, ex_valid, wb_valid;
    mem_pkg::word_t    ex_ins, ex_pc, ex_alu_res, ex_mlu_res, ex_reg_rt, ex_imm32;
    mem_pkg::reg_adr_t wb_adr;
    mem_pkg::word_t    wb_data, mem_adr, mem_wdata;
    mem_pkg::byte_en_t mem_byteen;

    // Reference model state.
    mem_pkg::word_t    model_mem [N_WORDS];
    logic              q_valid [$];
    logic              q_wen [$];
    mem_pkg::reg_adr_t q_adr [$];
    mem_pkg::word_t    q_data [$];
    logic              have_last;
    mem_pkg::byte_en_t last_be;
    mem_pkg::word_t    last_wd, last_alu;
    integer            seed;
    int                cycle_count, check_count, error_count, test_checks, test_errors;
    logic [5:0]        op;
    mem_pkg::word_t    a;

    logic [5:0] load_ops [5] = '{mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_LH,
                                 mem_pkg::OP_LHU, mem_pkg::OP_LW};
    logic [5:0] store_ops [3] = '{mem_pkg::OP_SW, mem_pkg::OP_SH, mem_pkg::OP_SB};
    logic [5:0] other_ops [5] = '{mem_pkg::OP_SPECIAL, mem_pkg::OP_SPECIAL, mem_pkg::OP_LUI,
                                  mem_pkg::OP_ORI, mem_pkg::OP_JAL};
    logic [5:0] other_fns [5] = '{mem_pkg::FN_ADDU, mem_pkg::FN_MFLO, 6'h00, 6'h00, 6'h00};

    tb_clock #(.PERIOD(8), .RESET_CYCLES(2)) u_clock (.clk(clk), .rst_n(rst_n));

    mem_stage #(.ADDR_WIDTH(10)) u_dut (
        .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_ins(ex_ins), .ex_pc(ex_pc),
        .ex_alu_res(ex_alu_res), .ex_mlu_res(ex_mlu_res), .ex_reg_rt(ex_reg_rt),
        .ex_imm32(ex_imm32), .wb_valid(wb_valid), .wb_adr(wb_adr), .wb_data(wb_data),
        .mem_adr(mem_adr), .mem_byteen(mem_byteen), .mem_wdata(mem_wdata)
    );

    // ############################
    // Helpers.
    task automatic check(input string name, input mem_pkg::word_t actual,
                         input mem_pkg::word_t expected);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic mem_pkg::word_t encode(input logic [5:0] op_f, input logic [5:0] fn,
                                              input mem_pkg::word_t base);
        base[`INS_OP]    = op_f;
        base[`INS_FUNCT] = fn;
        return base;
    endfunction

    function automatic mem_pkg::word_t rand_adr();
        return $random(seed) & 32'h0000_00ff;
    endfunction

    function automatic logic is_known(input logic [5:0] op_f);
        return (op_f == mem_pkg::OP_SPECIAL) || (op_f == mem_pkg::OP_JAL)
            || (op_f == mem_pkg::OP_ORI) || (op_f == mem_pkg::OP_LUI)
            || (op_f == mem_pkg::OP_JAP) || ((op_f >= 6'h20) && (op_f <= 6'h25))
            || (op_f == mem_pkg::OP_SB) || (op_f == mem_pkg::OP_SH) || (op_f == mem_pkg::OP_SW);
    endfunction

    function automatic mem_pkg::word_t load_value(input logic [5:0] op_f,
                                                  input mem_pkg::word_t word,
                                                  input logic [1:0] lane);
        mem_pkg::word_t lanes;
        lanes = word >> (8 * lane);
        case (op_f)
            mem_pkg::OP_LW:  return (lane == 2'b00) ? word : '0;
            mem_pkg::OP_LH:  return lane[0] ? '0 : {{16{lanes[15]}}, lanes[15:0]};
            mem_pkg::OP_LHU: return lane[0] ? '0 : {16'h0000, lanes[15:0]};
            mem_pkg::OP_LB:  return {{24{lanes[7]}}, lanes[7:0]};
            default:         return {24'h000000, lanes[7:0]};
        endcase
    endfunction

    // M outputs belong to the last issue, W outputs to the one before it.
    task automatic check_outputs();
        mem_pkg::word_t mask;
        mem_pkg::word_t exp_data;
        logic           wen;
        for (int i = 0; i < 4; i++)
            mask[8*i +: 8] = {8{last_be[i]}};
        if (have_last) begin
            check("mem_adr", mem_adr, last_alu);
            check("mem_byteen", mem_byteen, last_be);
            if (last_be != '0)
                check("mem_wdata", mem_wdata & mask, last_wd & mask);
        end
        if (q_valid.size() == 2) begin
            wen      = q_wen.pop_front();
            exp_data = q_data.pop_front();
            check("wb_valid", wb_valid, q_valid.pop_front());
            check("wb_adr", wb_adr, q_adr.pop_front());
            if (wen)
                check("wb_data", wb_data, exp_data);
        end
    endtask

    task automatic issue(input logic valid, input mem_pkg::word_t ins, input mem_pkg::word_t pc,
                         input mem_pkg::word_t alu, input mem_pkg::word_t rt);
        logic [5:0]        op_i, fn;
        logic [1:0]        lane;
        mem_pkg::word_t    word, mlu, imm, data, wd;
        mem_pkg::byte_en_t be;
        mem_pkg::reg_adr_t adr;
        logic              wen;
        @(negedge clk);
        check_outputs();
        mlu  = $random(seed);
        imm  = $random(seed);
        op_i = ins[`INS_OP];
        fn   = ins[`INS_FUNCT];
        lane = alu[1:0];
        word = model_mem[alu[7:2]];
        wd   = rt << (8 * lane); // Store data moved into its lane.
        be   = '0;
        wen  = 1'b0;
        adr  = ins[`INS_RT];
        data = load_value(op_i, word, lane);
        if (valid) begin
            case (op_i)
                mem_pkg::OP_SPECIAL: begin
                    wen  = (fn == mem_pkg::FN_ADDU) || (fn == mem_pkg::FN_MFLO);
                    adr  = ins[`INS_RD];
                    data = (fn == mem_pkg::FN_MFLO) ? mlu : alu;
                end
                mem_pkg::OP_LW, mem_pkg::OP_LH, mem_pkg::OP_LHU,
                mem_pkg::OP_LB, mem_pkg::OP_LBU: wen = 1'b1;
                mem_pkg::OP_SW: be = (lane == 2'b00) ? 4'b1111 : 4'b0000;
                mem_pkg::OP_SH: be = (lane == 2'b00) ? 4'b0011 : (lane == 2'b10) ? 4'b1100 : '0;
                mem_pkg::OP_SB: be = 4'b0001 << lane;
                mem_pkg::OP_LUI: begin
                    wen  = 1'b1;
                    data = imm;
                end
                mem_pkg::OP_ORI: begin
                    wen  = 1'b1;
                    data = alu;
                end
                mem_pkg::OP_JAL: begin
                    wen  = 1'b1;
                    adr  = mem_pkg::REG_RA;
                    data = pc + 32'd8;
                end
                mem_pkg::OP_JAP: begin
                    be   = 4'b1111;
                    wd   = pc + 32'd8;
                    wen  = 1'b1;
                    adr  = mem_pkg::REG_SP;
                    data = rt - 32'd4;
                end
                default: ;
            endcase
        end
        for (int i = 0; i < 4; i++)
            if (be[i])
                model_mem[alu[7:2]][8*i +: 8] = wd[8*i +: 8];
        ex_valid   = valid;
        ex_ins     = ins;
        ex_pc      = pc;
        ex_alu_res = alu;
        ex_mlu_res = mlu;
        ex_reg_rt  = rt;
        ex_imm32   = imm;
        q_valid.push_back(valid);
        q_wen.push_back(wen);
        q_adr.push_back(wen ? adr : '0);
        q_data.push_back(data);
        have_last = 1'b1;
        last_be   = be;
        last_wd   = wd;
        last_alu  = alu;
    endtask

    task automatic readback_all();
        for (int i = 0; i < N_WORDS; i++)
            issue(1'b1, encode(mem_pkg::OP_LW, 6'h00, $random(seed)), $random(seed), i * 4,
                  $random(seed));
    endtask

    task automatic finish_test(input string name);
        repeat (DRAIN)
            issue(1'b0, $random(seed), $random(seed), rand_adr(), $random(seed));
        $display("[TEST] %-16s %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // ############################
    // Timeout.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles.", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ############################
    // Tests.
    initial begin
        seed        = 98;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        have_last   = 1'b0;
        ex_valid    = 1'b1; // A live jap waits at the inputs through reset.
        ex_ins      = encode(mem_pkg::OP_JAP, 6'h00, '0);
        ex_pc       = '0;
        ex_alu_res  = '0;
        ex_mlu_res  = '0;
        ex_reg_rt   = '0;
        ex_imm32    = '0;
        wait (rst_n);
        check("wb_valid", wb_valid, '0);
        check("wb_adr", wb_adr, '0);
        check("mem_byteen", mem_byteen, '0);
        ex_valid = 1'b0;
        finish_test("reset");

        for (int i = 0; i < N_WORDS; i++) // Fill value mixes every address bit.
            issue(1'b1, encode(mem_pkg::OP_SW, 6'h00, $random(seed)), $random(seed), i * 4,
                  (i * 4 * 32'h9e37_79b1) ^ 32'h5a5a_c3c3);
        finish_test("memory_fill");

        for (int i = 0; i < N_RAND; i++)
            issue(1'b1, encode(store_ops[{$random(seed)} % 3], 6'h00, $random(seed)),
                  $random(seed), rand_adr(), $random(seed));
        readback_all();
        finish_test("store_roundtrip");

        for (int i = 0; i < N_RAND; i++)
            issue(1'b1, encode(load_ops[{$random(seed)} % 5], 6'h00, $random(seed)),
                  $random(seed), rand_adr(), $random(seed));
        finish_test("load_extension");

        for (int i = 0; i < N_RAND; i++) begin
            op = {$random(seed)} % 5;
            issue(1'b1, encode(other_ops[op], other_fns[op], $random(seed)), $random(seed),
                  $random(seed), $random(seed));
        end
        finish_test("other_sources");

        for (int i = 0; i < N_JAP; i++) begin
            a = rand_adr() & 32'hffff_fffc;
            issue(1'b1, encode(mem_pkg::OP_JAP, 6'h00, $random(seed)), $random(seed), a,
                  $random(seed));
            issue(1'b1, encode(mem_pkg::OP_LW, 6'h00, $random(seed)), $random(seed), a,
                  $random(seed));
        end
        finish_test("jap_push");

        for (int i = 0; i < N_RAND; i++) begin
            if ($random(seed) & 1) begin
                issue(1'b0, encode(mem_pkg::OP_SW, 6'h00, $random(seed)), $random(seed),
                      rand_adr() & 32'hffff_fffc, $random(seed));
            end else begin
                op = $random(seed);
                while (is_known(op))
                    op = $random(seed);
                issue(1'b1, encode(op, 6'h00, $random(seed)), $random(seed), rand_adr(),
                      $random(seed));
            end
        end
        readback_all();
        finish_test("idle_unknown");

        error_count += u_dut.u_assertions.failures;
        $display("Totals: %0d checks, %0d errors, %0d assertion failures", check_count,
                 error_count, u_dut.u_assertions.failures);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/mem_stage_assertions.sv
`timescale 1ns/1ps

module mem_stage_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                wb_valid,
    input mem_pkg::reg_adr_t   wb_adr,
    input mem_pkg::word_t      wb_data,
    input mem_pkg::byte_en_t   mem_byteen
);

    int failures = 0;

    // None, one byte, an aligned halfword or the full word.
    a_byteen_legal: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(mem_byteen) || (mem_byteen == 4'b0011) || (mem_byteen == 4'b1100)
        || (mem_byteen == 4'b1111))
    else begin
        failures++;
        $error("mem_byteen holds an illegal pattern");
    end

    a_idle_adr: assert property (@(posedge clk) disable iff (!rst_n)
        !wb_valid |-> (wb_adr == '0))
    else begin
        failures++;
        $error("wb_adr is nonzero while wb_valid is low");
    end

    a_known_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({wb_valid, wb_adr, mem_byteen}))
    else begin
        failures++;
        $error("control outputs are unknown");
    end

    a_known_data: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> !$isunknown(wb_data))
    else begin
        failures++;
        $error("wb_data is unknown on a valid writeback");
    end

endmodule

bind mem_stage mem_stage_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .wb_valid(wb_valid), .wb_adr(wb_adr),
    .wb_data(wb_data), .mem_byteen(mem_byteen)
);

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // Released away from the active edge.
    end

endmodule

// File: source/mem_stage.sv
`timescale 1ns/1ps

module mem_stage #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ex_valid,
    input  mem_pkg::word_t      ex_ins,
    input  mem_pkg::word_t      ex_pc,
    input  mem_pkg::word_t      ex_alu_res,
    input  mem_pkg::word_t      ex_mlu_res,
    input  mem_pkg::word_t      ex_reg_rt,
    input  mem_pkg::word_t      ex_imm32,
    output logic                wb_valid,
    output mem_pkg::reg_adr_t   wb_adr,
    output mem_pkg::word_t      wb_data,
    output mem_pkg::word_t      mem_adr,
    output mem_pkg::byte_en_t   mem_byteen,
    output mem_pkg::word_t      mem_wdata
);

    // ############################
    // M-stage bus.
    logic                      m_valid;
    mem_pkg::word_t            m_ins;
    mem_pkg::word_t            m_pc;
    mem_pkg::word_t            m_mlu_res;
    mem_pkg::word_t            m_reg_rt;
    mem_pkg::word_t            m_imm32;
    logic                      mem_wen;
    logic                      reg_wen;
    mem_pkg::wb_src_t          wb_src;
    mem_pkg::wb_dst_t          wb_dst;
    mem_pkg::access_width_t    width;
    logic                      sign_ext;
    logic                      push;

    mem_pkg::word_t            link_addr;
    mem_pkg::word_t            rdata;
    mem_pkg::word_t            load_data;

    // The ALU result is the memory address.
    mem_decode u_decode (
        .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_ins(ex_ins), .ex_pc(ex_pc),
        .ex_alu_res(ex_alu_res), .ex_mlu_res(ex_mlu_res), .ex_reg_rt(ex_reg_rt),
        .ex_imm32(ex_imm32), .m_valid(m_valid), .m_ins(m_ins), .m_pc(m_pc),
        .m_alu_res(mem_adr), .m_mlu_res(m_mlu_res), .m_reg_rt(m_reg_rt), .m_imm32(m_imm32),
        .mem_wen(mem_wen), .reg_wen(reg_wen), .wb_src(wb_src), .wb_dst(wb_dst),
        .width(width), .sign_ext(sign_ext), .push(push)
    );

    store_align u_store (
        .push(push), .mem_wen(mem_wen), .width(width), .adr(mem_adr),
        .reg_rt(m_reg_rt), .link_addr(link_addr), .byteen(mem_byteen), .wdata(mem_wdata)
    );

    load_extract u_load (
        .sign_ext(sign_ext), .width(width), .adr(mem_adr), .rdata(rdata),
        .load_data(load_data)
    );

    writeback_select u_wb (
        .clk(clk), .rst_n(rst_n), .m_valid(m_valid), .reg_wen(reg_wen),
        .wb_src(wb_src), .wb_dst(wb_dst), .m_ins(m_ins), .m_pc(m_pc),
        .m_alu_res(mem_adr), .m_mlu_res(m_mlu_res), .m_reg_rt(m_reg_rt),
        .m_imm32(m_imm32), .load_data(load_data), .link_addr(link_addr),
        .wb_valid(wb_valid), .wb_adr(wb_adr), .wb_data(wb_data)
    );

    data_ram #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_ram (
        .clk(clk),
        .adr(mem_adr[ADDR_WIDTH+1:2]), // Word index.
        .byteen(mem_byteen),
        .wdata(mem_wdata),
        .rdata(rdata)
    );

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                    clk,
    input  logic [ADDR_WIDTH-1:0]   adr,
    input  mem_pkg::byte_en_t       byteen,
    input  mem_pkg::word_t          wdata,
    output mem_pkg::word_t          rdata
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    mem_pkg::word_t mem [DEPTH];

    // Byte lanes are written independently.
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byteen[i])
                mem[adr][8*i +: 8] <= wdata[8*i +: 8];
        end
    end

    assign rdata = mem[adr]; // Asynchronous read.

endmodule

// File: source/writeback_select.sv
`timescale 1ns/1ps
`include "instr_fields.svh"

module writeback_select (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                m_valid,
    input  logic                reg_wen,
    input  mem_pkg::wb_src_t    wb_src,
    input  mem_pkg::wb_dst_t    wb_dst,
    input  mem_pkg::word_t      m_ins,
    input  mem_pkg::word_t      m_pc,
    input  mem_pkg::word_t      m_alu_res,
    input  mem_pkg::word_t      m_mlu_res,
    input  mem_pkg::word_t      m_reg_rt,
    input  mem_pkg::word_t      m_imm32,
    input  mem_pkg::word_t      load_data,
    output mem_pkg::word_t      link_addr,
    output logic                wb_valid,
    output mem_pkg::reg_adr_t   wb_adr,
    output mem_pkg::word_t      wb_data
);

    mem_pkg::reg_adr_t dst_adr;
    mem_pkg::word_t    dst_data;

    assign link_addr = m_pc + 32'd8;

    always_comb begin
        case (wb_dst)
            mem_pkg::DST_RT: dst_adr = m_ins[`INS_RT];
            mem_pkg::DST_RD: dst_adr = m_ins[`INS_RD];
            mem_pkg::DST_RA: dst_adr = mem_pkg::REG_RA;
            default:         dst_adr = mem_pkg::REG_SP;
        endcase
        if (!reg_wen)
            dst_adr = '0;
    end

    always_comb begin
        case (wb_src)
            mem_pkg::SRC_IMM:   dst_data = m_imm32;
            mem_pkg::SRC_LINK:  dst_data = link_addr;
            mem_pkg::SRC_MLU:   dst_data = m_mlu_res;
            mem_pkg::SRC_LOAD:  dst_data = load_data;
            mem_pkg::SRC_STACK: dst_data = m_reg_rt - 32'd4; // New stack pointer.
            default:            dst_data = m_alu_res;
        endcase
    end

    // W pipeline register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_adr   <= '0;
        end else begin
            wb_valid <= m_valid;
            wb_adr   <= dst_adr;
        end
    end

    always_ff @(posedge clk) wb_data <= dst_data;

endmodule

// File: source/load_extract.sv
`timescale 1ns/1ps

module load_extract (
    input  logic                      sign_ext,
    input  mem_pkg::access_width_t    width,
    input  mem_pkg::word_t            adr,
    input  mem_pkg::word_t            rdata,
    output mem_pkg::word_t            load_data
);

    mem_pkg::word_t shifted;
    logic [15:0]    half;
    logic [7:0]     byte_val;

    // Addressed lane moved down to bit 0.
    assign shifted  = rdata >> {adr[1:0], 3'b000};
    assign half     = shifted[15:0];
    assign byte_val = shifted[7:0];

    always_comb begin
        load_data = '0;
        case (width)
            mem_pkg::WIDTH_WORD: begin
                if (adr[1:0] == 2'b00)
                    load_data = rdata;
            end
            mem_pkg::WIDTH_HALF: begin
                if (!adr[0]) begin
                    if (sign_ext)
                        load_data = {{16{half[15]}}, half};
                    else
                        load_data = {16'h0000, half};
                end
            end
            mem_pkg::WIDTH_BYTE: begin
                if (sign_ext)
                    load_data = {{24{byte_val[7]}}, byte_val};
                else
                    load_data = {24'h000000, byte_val};
            end
            default: ; // No load.
        endcase
    end

endmodule

// File: source/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  logic                      push,
    input  logic                      mem_wen,
    input  mem_pkg::access_width_t    width,
    input  mem_pkg::word_t            adr,
    input  mem_pkg::word_t            reg_rt,
    input  mem_pkg::word_t            link_addr,
    output mem_pkg::byte_en_t         byteen,
    output mem_pkg::word_t            wdata
);

    logic [1:0] lane;

    assign lane = adr[1:0];

    always_comb begin
        byteen = '0;
        wdata  = '0;
        if (push) begin
            byteen = 4'b1111; // Link word goes out whole.
            wdata  = link_addr;
        end else if (mem_wen) begin
            case (width)
                mem_pkg::WIDTH_WORD: begin
                    if (lane == 2'b00) begin
                        byteen = 4'b1111;
                        wdata  = reg_rt;
                    end
                end
                mem_pkg::WIDTH_HALF: begin
                    if (lane == 2'b00) begin
                        byteen = 4'b0011;
                        wdata  = reg_rt;
                    end else if (lane == 2'b10) begin
                        byteen = 4'b1100;
                        wdata  = reg_rt << 16;
                    end
                end
                mem_pkg::WIDTH_BYTE: begin
                    byteen = 4'b0001 << lane;
                    wdata  = reg_rt << {lane, 3'b000}; // Byte into its lane.
                end
                default: ;
            endcase
        end
    end

endmodule

// File: source/mem_decode.sv
`timescale 1ns/1ps
`include "instr_fields.svh"

module mem_decode (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ex_valid,
    input  mem_pkg::word_t            ex_ins,
    input  mem_pkg::word_t            ex_pc,
    input  mem_pkg::word_t            ex_alu_res,
    input  mem_pkg::word_t            ex_mlu_res,
    input  mem_pkg::word_t            ex_reg_rt,
    input  mem_pkg::word_t            ex_imm32,
    output logic                      m_valid,
    output mem_pkg::word_t            m_ins,
    output mem_pkg::word_t            m_pc,
    output mem_pkg::word_t            m_alu_res,
    output mem_pkg::word_t            m_mlu_res,
    output mem_pkg::word_t            m_reg_rt,
    output mem_pkg::word_t            m_imm32,
    output logic                      mem_wen,
    output logic                      reg_wen,
    output mem_pkg::wb_src_t          wb_src,
    output mem_pkg::wb_dst_t          wb_dst,
    output mem_pkg::access_width_t    width,
    output logic                      sign_ext,
    output logic                      push
);

    logic [5:0] op;
    logic [5:0] funct;

    // ############################
    // M pipeline register.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
            m_ins   <= '0;
        end else begin
            m_valid <= ex_valid;
            m_ins   <= ex_ins;
        end
    end

    always_ff @(posedge clk) begin
        m_pc      <= ex_pc;
        m_alu_res <= ex_alu_res;
        m_mlu_res <= ex_mlu_res;
        m_reg_rt  <= ex_reg_rt;
        m_imm32   <= ex_imm32;
    end

    assign op    = m_ins[`INS_OP];
    assign funct = m_ins[`INS_FUNCT];

    // ############################
    // Control decode.
    always_comb begin
        mem_wen  = 1'b0;
        reg_wen  = 1'b0;
        wb_src   = mem_pkg::SRC_ALU;
        wb_dst   = mem_pkg::DST_RT;
        width    = mem_pkg::WIDTH_NONE;
        sign_ext = 1'b0;
        push     = 1'b0;
        case (op)
            mem_pkg::OP_SPECIAL: begin
                if (funct == mem_pkg::FN_ADDU) begin
                    reg_wen = 1'b1;
                    wb_dst  = mem_pkg::DST_RD;
                end else if (funct == mem_pkg::FN_MFLO) begin
                    reg_wen = 1'b1;
                    wb_src  = mem_pkg::SRC_MLU;
                    wb_dst  = mem_pkg::DST_RD;
                end
            end
            mem_pkg::OP_LW, mem_pkg::OP_LH, mem_pkg::OP_LHU,
            mem_pkg::OP_LB, mem_pkg::OP_LBU: begin
                reg_wen  = 1'b1;
                wb_src   = mem_pkg::SRC_LOAD;
                sign_ext = (op == mem_pkg::OP_LH) || (op == mem_pkg::OP_LB);
                if (op == mem_pkg::OP_LW)
                    width = mem_pkg::WIDTH_WORD;
                else if ((op == mem_pkg::OP_LH) || (op == mem_pkg::OP_LHU))
                    width = mem_pkg::WIDTH_HALF;
                else
                    width = mem_pkg::WIDTH_BYTE;
            end
            mem_pkg::OP_SW: begin mem_wen = 1'b1; width = mem_pkg::WIDTH_WORD; end
            mem_pkg::OP_SH: begin mem_wen = 1'b1; width = mem_pkg::WIDTH_HALF; end
            mem_pkg::OP_SB: begin mem_wen = 1'b1; width = mem_pkg::WIDTH_BYTE; end
            mem_pkg::OP_LUI: begin reg_wen = 1'b1; wb_src = mem_pkg::SRC_IMM; end
            mem_pkg::OP_ORI: reg_wen = 1'b1; // ALU result to rt.
            mem_pkg::OP_JAL: begin
                reg_wen = 1'b1;
                wb_src  = mem_pkg::SRC_LINK;
                wb_dst  = mem_pkg::DST_RA;
            end
            mem_pkg::OP_JAP: begin
                push    = 1'b1;
                reg_wen = 1'b1;
                wb_src  = mem_pkg::SRC_STACK;
                wb_dst  = mem_pkg::DST_SP;
            end
            default: ;
        endcase
        if (!m_valid) begin // Empty slot writes nothing.
            mem_wen = 1'b0;
            reg_wen = 1'b0;
            push    = 1'b0;
            width   = mem_pkg::WIDTH_NONE;
        end
    end

endmodule

// File: source/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_adr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [1:0]  access_width_t;
    typedef logic [2:0]  wb_src_t;
    typedef logic [1:0]  wb_dst_t;

    // ############################
    // Access width.
    localparam access_width_t WIDTH_NONE = 2'd0;
    localparam access_width_t WIDTH_WORD = 2'd1;
    localparam access_width_t WIDTH_HALF = 2'd2;
    localparam access_width_t WIDTH_BYTE = 2'd3;

    // ############################
    // Writeback value source and destination.
    localparam wb_src_t SRC_ALU   = 3'd0;
    localparam wb_src_t SRC_IMM   = 3'd1;
    localparam wb_src_t SRC_LINK  = 3'd2; // PC+8.
    localparam wb_src_t SRC_MLU   = 3'd3;
    localparam wb_src_t SRC_LOAD  = 3'd4;
    localparam wb_src_t SRC_STACK = 3'd5; // rt-4.

    localparam wb_dst_t DST_RT = 2'd0;
    localparam wb_dst_t DST_RD = 2'd1;
    localparam wb_dst_t DST_RA = 2'd2;
    localparam wb_dst_t DST_SP = 2'd3;

    localparam reg_adr_t REG_RA = 5'd31;
    localparam reg_adr_t REG_SP = 5'd29;

    // ############################
    // Opcodes and funct codes.
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SW      = 6'h2b;
    localparam logic [5:0] OP_JAP     = 6'h3b; // Push link, custom.

    localparam logic [5:0] FN_MFLO = 6'h12;
    localparam logic [5:0] FN_ADDU = 6'h21;

endpackage

// File: include/instr_fields.svh
`ifndef INSTR_FIELDS_SVH
`define INSTR_FIELDS_SVH

// Bit ranges of the fields in a 32-bit instruction word.

`define INS_OP    31:26
`define INS_RS    25:21
`define INS_RT    20:16
`define INS_RD    15:11
`define INS_SHAMT 10:6
`define INS_FUNCT 5:0

// Immediate and jump target fields.
`define INS_IMM   15:0
`define INS_TGT   25:0

`endif
